// File: hdl/spi_pkg.sv
// shared definitions for the spi master subsystem
package spi_pkg;

  // divider exponent, sclk phase lasts 2**freq_exp clk cycles
  localparam int freq_bits = 3;

  // phase hold counter, must hold 2**7 - 1
  localparam int hold_bits = 7;

  // transfer sequencer states
  typedef enum logic [3:0] {
    idle,            // waiting for a request
    start0,          // cs low, rx register cleared
    start1,          // cs low, first miso sample
    sclk_high,       // first cycle of sclk high
    sclk_high_hold,  // remaining high cycles
    sclk_low,        // first cycle of sclk low
    sclk_low_hold,   // remaining low cycles
    cs_hold,         // one extra cycle with cs still low
    done             // response waiting on send_rdy
  } spi_state_t;

  // spi_state_t fits in 4 bits with room left for
  // later modes 1 to 3 if they get their own states

endpackage

// File: hdl/spi_config_regs.sv
`timescale 1ns/1ns

// run-time configuration, written over three val/rdy channels
module spi_config_regs #(
  parameter int nbits = 34,
  parameter int ncs = 1
) (
  input  logic clk,
  input  logic reset,
  input  logic idle,  // master is idle or done

  input  logic size_val,
  input  logic cs_addr_val,
  input  logic freq_val,

  input  logic [$clog2(nbits):0]                      size_msg,
  input  logic [((ncs > 1) ? $clog2(ncs) : 1)-1:0]    cs_addr_msg,
  input  logic [spi_pkg::freq_bits-1:0]               freq_msg,

  output logic size_rdy,
  output logic cs_addr_rdy,
  output logic freq_rdy,

  output logic [$clog2(nbits):0]                      packet_size,
  output logic [((ncs > 1) ? $clog2(ncs) : 1)-1:0]    cs_addr,
  output logic [spi_pkg::freq_bits-1:0]               freq_exp
);

  localparam int size_bits = $clog2(nbits) + 1;  // holds nbits itself
  localparam int cs_bits = (ncs > 1) ? $clog2(ncs) : 1;

  // writes only between transfers, ready mirrors the master
  assign size_rdy    = idle;
  assign cs_addr_rdy = idle;
  assign freq_rdy    = idle;

  always_ff @(posedge clk) begin
    if (reset) begin
      packet_size <= '0;
      cs_addr     <= '0;
      freq_exp    <= '0;
    end else begin
      if (size_val && size_rdy)
        packet_size <= size_msg[size_bits-1:0];  // bits per word
      if (cs_addr_val && cs_addr_rdy)
        cs_addr <= cs_addr_msg[cs_bits-1:0];     // which cs goes low
      if (freq_val && freq_rdy)
        freq_exp <= freq_msg;                    // sclk divider exponent
    end
  end

  // a write on the accept edge is seen by the next
  // transfer, the master already latched its counters

endmodule

// File: hdl/spi_shift_reg.sv
`timescale 1ns/1ns

// parallel-load shift register, shifts toward the msb
// tx side: load word, mosi from the msb
// rx side: clear at start, miso in at the lsb
module spi_shift_reg #(
  parameter int width = 34
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             clear,       // zero the whole register
  input  logic             load,        // take load_value
  input  logic [width-1:0] load_value,
  input  logic             shift,       // one step toward msb
  input  logic             serial_in,   // enters at bit 0
  output logic [width-1:0] q
);

  // priority reset, clear, load, shift
  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;
    end else if (clear) begin
      q <= '0;
    end else if (load) begin
      q <= load_value;
    end else if (shift) begin
      q <= {q[width-2:0], serial_in};  // msb drops out
    end
  end

  // no shift, no load: q holds

endmodule

// File: hdl/spi_master.sv
`timescale 1ns/1ns

// spi mode 0 transfer sequencer
module spi_master #(
  parameter int nbits = 34,
  parameter int ncs = 1
) (
  input  logic clk,
  input  logic reset,

  input  logic recv_val,
  output logic recv_rdy,
  output logic send_val,
  input  logic send_rdy,

  input  logic [$clog2(nbits):0]                      packet_size,
  input  logic [((ncs > 1) ? $clog2(ncs) : 1)-1:0]    cs_addr,
  input  logic [spi_pkg::freq_bits-1:0]               freq_exp,

  output logic                   accept,      // recv handshake this cycle
  output logic [$clog2(nbits):0] load_shift,  // left-align amount for tx load
  output logic                   rx_clear,
  output logic                   sample,      // rx takes miso
  output logic                   shift_out,   // tx moves next bit to mosi
  output logic                   sclk,
  output logic                   cs [ncs]
);

  localparam int size_bits = $clog2(nbits) + 1;
  localparam int cs_bits = (ncs > 1) ? $clog2(ncs) : 1;

  spi_pkg::spi_state_t state;
  spi_pkg::spi_state_t next_state;

  logic [size_bits-1:0]          bit_cnt;   // bits still to clock
  logic [spi_pkg::hold_bits-1:0] high_cnt;  // high cycles left after this one
  logic [spi_pkg::hold_bits-1:0] low_cnt;   // low cycles left after this one
  logic [spi_pkg::hold_bits-1:0] hold_len;
  logic [cs_bits-1:0]            cs_sel;    // cs_addr of the word in flight
  logic [spi_pkg::freq_bits-1:0] freq_sel;  // freq_exp of the word in flight
  logic                          in_high;
  logic                          in_low;
  logic                          active;    // cs asserted

  // 2**freq_sel - 1 extra cycles per phase
  assign hold_len = spi_pkg::hold_bits'((1 << freq_sel) - 1);

  assign in_high = (state == spi_pkg::sclk_high) || (state == spi_pkg::sclk_high_hold);
  assign in_low  = (state == spi_pkg::sclk_low) || (state == spi_pkg::sclk_low_hold);
  assign active  = (state == spi_pkg::start0) || (state == spi_pkg::start1) ||
                   in_high || in_low || (state == spi_pkg::cs_hold);

  assign recv_rdy = (state == spi_pkg::idle) || (state == spi_pkg::done);
  assign send_val = (state == spi_pkg::done);
  assign accept   = recv_val && recv_rdy;
  assign sclk     = in_high;

  // word sits in the top packet_size bits of tx
  assign load_shift = size_bits'(nbits) - packet_size;

  assign rx_clear = (state == spi_pkg::start0);

  // sample as sclk rises, shift mosi as sclk falls, never in mid-phase
  assign sample    = (state == spi_pkg::start1) ||
                     (in_low && (low_cnt == '0) && (bit_cnt != '0));
  assign shift_out = in_high && (high_cnt == '0);

  always_ff @(posedge clk) begin
    if (reset)
      state <= spi_pkg::idle;
    else
      state <= next_state;
  end

  always_comb begin
    next_state = state;
    case (state)
      spi_pkg::idle:
        if (recv_val) next_state = spi_pkg::start0;
      spi_pkg::start0: next_state = spi_pkg::start1;
      spi_pkg::start1: next_state = spi_pkg::sclk_high;
      spi_pkg::sclk_high, spi_pkg::sclk_high_hold:
        next_state = (high_cnt == '0) ? spi_pkg::sclk_low : spi_pkg::sclk_high_hold;
      spi_pkg::sclk_low, spi_pkg::sclk_low_hold: begin
        if (low_cnt != '0)
          next_state = spi_pkg::sclk_low_hold;
        else if (bit_cnt == '0)
          next_state = spi_pkg::cs_hold;  // last bit clocked
        else
          next_state = spi_pkg::sclk_high;
      end
      spi_pkg::cs_hold: next_state = spi_pkg::done;
      spi_pkg::done: begin
        if (recv_val)
          next_state = spi_pkg::start0;   // back to back, skip idle
        else if (send_rdy)
          next_state = spi_pkg::idle;
      end
      default: next_state = spi_pkg::idle;
    endcase
  end

  // one decrement per bit, on its first high cycle
  always_ff @(posedge clk) begin
    if (reset)
      bit_cnt <= '0;
    else if (accept)
      bit_cnt <= packet_size;  // latched here, later cfg writes wait
    else if (state == spi_pkg::sclk_high)
      bit_cnt <= bit_cnt - 1'b1;
  end

  // chip select and divider fixed for the whole word
  always_ff @(posedge clk) begin
    if (reset) begin
      cs_sel   <= '0;
      freq_sel <= '0;
    end else if (accept) begin
      cs_sel   <= cs_addr;
      freq_sel <= freq_exp;
    end
  end

  // phase counters, each refilled as the other phase begins
  always_ff @(posedge clk) begin
    if (reset) begin
      high_cnt <= '0;
      low_cnt  <= '0;
    end else begin
      if ((state == spi_pkg::start1) || (state == spi_pkg::sclk_low))
        high_cnt <= hold_len;
      else if (in_high && (high_cnt != '0))
        high_cnt <= high_cnt - 1'b1;

      if (state == spi_pkg::sclk_high)
        low_cnt <= hold_len;
      else if (in_low && (low_cnt != '0))
        low_cnt <= low_cnt - 1'b1;
    end
  end

  // one-cold chip select
  always_comb begin
    for (int i = 0; i < ncs; i++)
      cs[i] = 1'b1;
    if (active)
      cs[cs_sel] = 1'b0;
  end

endmodule

// File: hdl/spi_top.sv
`timescale 1ns/1ns

// spi mode 0 master with its configuration registers
module spi_top #(
  parameter int nbits = 34,
  parameter int ncs = 1
) (
  input  logic clk,
  input  logic reset,

  // spi pins
  output logic sclk,
  output logic mosi,
  input  logic miso,
  output logic cs [ncs],

  // word to send
  input  logic             recv_val,
  output logic             recv_rdy,
  input  logic [nbits-1:0] recv_msg,

  // word received
  output logic             send_val,
  input  logic             send_rdy,
  output logic [nbits-1:0] send_msg,

  input  logic                                        size_val,
  output logic                                        size_rdy,
  input  logic [$clog2(nbits):0]                      size_msg,

  input  logic                                        cs_addr_val,
  output logic                                        cs_addr_rdy,
  input  logic [((ncs > 1) ? $clog2(ncs) : 1)-1:0]    cs_addr_msg,

  input  logic                                        freq_val,
  output logic                                        freq_rdy,
  input  logic [spi_pkg::freq_bits-1:0]               freq_msg
);

  localparam int size_bits = $clog2(nbits) + 1;
  localparam int cs_bits = (ncs > 1) ? $clog2(ncs) : 1;

  logic [size_bits-1:0]          packet_size;
  logic [cs_bits-1:0]            cs_addr;
  logic [spi_pkg::freq_bits-1:0] freq_exp;
  logic                          accept;
  logic [size_bits-1:0]          load_shift;
  logic                          rx_clear;
  logic                          sample;
  logic                          shift_out;
  logic [nbits-1:0]              tx_q;

  spi_config_regs #(.nbits(nbits), .ncs(ncs)) cfg (
    .clk(clk), .reset(reset), .idle(recv_rdy),
    .size_val(size_val), .cs_addr_val(cs_addr_val), .freq_val(freq_val),
    .size_msg(size_msg), .cs_addr_msg(cs_addr_msg), .freq_msg(freq_msg),
    .size_rdy(size_rdy), .cs_addr_rdy(cs_addr_rdy), .freq_rdy(freq_rdy),
    .packet_size(packet_size), .cs_addr(cs_addr), .freq_exp(freq_exp)
  );

  spi_master #(.nbits(nbits), .ncs(ncs)) master (
    .clk(clk), .reset(reset),
    .recv_val(recv_val), .recv_rdy(recv_rdy),
    .send_val(send_val), .send_rdy(send_rdy),
    .packet_size(packet_size), .cs_addr(cs_addr), .freq_exp(freq_exp),
    .accept(accept), .load_shift(load_shift), .rx_clear(rx_clear),
    .sample(sample), .shift_out(shift_out), .sclk(sclk), .cs(cs)
  );

  // tx: word left-aligned on accept, msb drives mosi
  spi_shift_reg #(.width(nbits)) tx_shreg (
    .clk(clk), .reset(reset), .clear(1'b0),
    .load(accept), .load_value(recv_msg << load_shift),
    .shift(shift_out), .serial_in(1'b0), .q(tx_q)
  );

  // rx: miso enters at the lsb, first bit ends up highest
  spi_shift_reg #(.width(nbits)) rx_shreg (
    .clk(clk), .reset(reset), .clear(rx_clear),
    .load(1'b0), .load_value({nbits{1'b0}}),
    .shift(sample), .serial_in(miso), .q(send_msg)
  );

  assign mosi = tx_q[nbits-1];

endmodule

// File: test/spi_slave_model.sv
`timescale 1ns/1ns

// behavioral mode 0 spi slave
// one register in a loop with the master, msb out on miso, mosi in at the lsb
module spi_slave_model #(
  parameter int width = 34,
  parameter logic [width-1:0] init_value = '0
) (
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  input  logic select_n  // low while any chip select is low
);

  logic [width-1:0] shreg;

  // fixed start pattern, the testbench mirrors it
  initial begin
    shreg = init_value;
  end

  // msb stays on miso until the next rising sclk
  assign miso = shreg[width-1];

  // mode 0, data taken on the rising edge
  always @(posedge sclk) begin
    if (!select_n)
      shreg <= {shreg[width-2:0], mosi};  // old msb has already been sampled
  end

  // no reset pin here, sclk is the only clock of this model

endmodule

// File: test/spi_assertions.sv
`timescale 1ns/1ns

// protocol checks on the spi master pins
module spi_assertions #(
  parameter int ncs = 1
) (
  input logic                clk,
  input logic                reset,
  input spi_pkg::spi_state_t state,
  input logic                sclk,
  input logic                send_val,
  input logic                cs [ncs]
);

  logic [ncs-1:0] cs_low;    // one bit per selected device
  logic           in_phase;  // any sclk high or low state
  int             fail_count = 0;

  always_comb begin
    for (int i = 0; i < ncs; i++)
      cs_low[i] = !cs[i];
  end

  assign in_phase = (state == spi_pkg::sclk_high) || (state == spi_pkg::sclk_high_hold) ||
                    (state == spi_pkg::sclk_low) || (state == spi_pkg::sclk_low_hold);

  // never two devices selected at once
  one_cs_low: assert property (@(posedge clk) disable iff (reset) $onehot0(cs_low))
    else begin
      $error("more than one chip select low");
      fail_count++;
    end

  // sclk parked low with no device selected
  sclk_parked: assert property (@(posedge clk) disable iff (reset) (cs_low == '0) |-> !sclk)
    else begin
      $error("sclk high while every chip select is high");
      fail_count++;
    end

  // response only after the last phase
  no_send_in_phase: assert property (@(posedge clk) disable iff (reset) !(send_val && in_phase))
    else begin
      $error("send_val high during an sclk phase");
      fail_count++;
    end

endmodule

bind spi_master spi_assertions #(.ncs(ncs)) asrt (
  .clk(clk), .reset(reset), .state(state), .sclk(sclk), .send_val(send_val), .cs(cs)
);

// File: test/tb_spi_top.sv
`timescale 1ns/1ns

module tb_spi_top;

  localparam int nbits = 34;
  localparam int ncs = 4;
  localparam int size_bits = $clog2(nbits) + 1;
  localparam int num_transfers = 48;
  localparam int period = 20;
  localparam int worst_frame = 3 + nbits * 8;  // full word at exponent 2
  // reset, then each transfer with hold, config writes and release
  localparam int limit_ns = (16 + num_transfers * (worst_frame + 40) + 100) * period;
  localparam logic [nbits-1:0] slave_init = 34'h29d3c5a17;

  logic clk;
  logic reset;
  logic sclk, mosi, miso, select_n;
  logic cs [ncs];
  logic recv_val, recv_rdy, send_val, send_rdy;
  logic [nbits-1:0] recv_msg;
  logic [nbits-1:0] send_msg;
  logic size_val, size_rdy, cs_addr_val, cs_addr_rdy, freq_val, freq_rdy;
  logic [size_bits-1:0] size_msg;
  logic [1:0] cs_addr_msg;
  logic [spi_pkg::freq_bits-1:0] freq_msg;

  logic [31:0] lfsr_state = 32'heec8f6d2;
  int cycle = 0;
  int cur_n, cur_f, cur_cs;         // config the dut holds now
  logic [nbits-1:0] ref_reg = slave_init;  // mirror of the slave register
  // expectations for the frame in flight
  int frame_start, frame_len, frame_f, frame_cs;
  logic frame_valid = 1'b0;
  logic [nbits-1:0] frame_mask, exp_rx, exp_reg;
  // monitor state
  int checked = 0;
  int high_run = 0;
  logic in_frame;
  logic send_val_q = 1'b0;
  logic release_q = 1'b0;  // send_rdy or recv_val seen by the coming edge
  logic [nbits-1:0] held_msg;
  int t, n, f, c, hold;
  logic [nbits-1:0] msg;

  spi_top #(.nbits(nbits), .ncs(ncs)) uut (
    .clk(clk), .reset(reset), .sclk(sclk), .mosi(mosi), .miso(miso), .cs(cs),
    .recv_val(recv_val), .recv_rdy(recv_rdy), .recv_msg(recv_msg),
    .send_val(send_val), .send_rdy(send_rdy), .send_msg(send_msg),
    .size_val(size_val), .size_rdy(size_rdy), .size_msg(size_msg),
    .cs_addr_val(cs_addr_val), .cs_addr_rdy(cs_addr_rdy), .cs_addr_msg(cs_addr_msg),
    .freq_val(freq_val), .freq_rdy(freq_rdy), .freq_msg(freq_msg)
  );

  // one slave answers on every chip select
  assign select_n = cs[0] & cs[1] & cs[2] & cs[3];

  spi_slave_model #(.width(nbits), .init_value(slave_init)) slave (
    .sclk(sclk), .mosi(mosi), .miso(miso), .select_n(select_n)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;  // edge count, read between edges

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // galois, right shift
  endfunction

  // one lfsr step per bit taken
  function automatic logic [nbits-1:0] random_bits(input int count);
    logic [nbits-1:0] v;
    v = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[nbits-2:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // slave loop: its msb goes out as each sclk rises, mosi bit n-1 enters first
  function automatic void slave_reference(input logic [nbits-1:0] prev,
                                          input logic [nbits-1:0] word, input int count,
                                          output logic [nbits-1:0] rx,
                                          output logic [nbits-1:0] next);
    logic [nbits-1:0] r;
    r = prev;
    rx = '0;
    for (int k = 0; k < count; k++) begin
      rx = {rx[nbits-2:0], r[nbits-1]};
      r = {r[nbits-2:0], word[count-1-k]};
    end
    next = r;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [nbits-1:0] got,
                             input logic [nbits-1:0] expected);
    fail_run($sformatf("ERR %0t %s: got %h, expected %h", $time, name, got, expected));
  endtask

  // all three channels in one cycle, only between transfers
  task automatic write_config(input int size, input int fexp, input int sel);
    @(posedge clk);
    #2;
    size_val = 1'b1;
    size_msg = size_bits'(size);
    freq_val = 1'b1;
    freq_msg = spi_pkg::freq_bits'(fexp);
    cs_addr_val = 1'b1;
    cs_addr_msg = 2'(sel);
    @(negedge clk);
    assert (size_rdy && freq_rdy && cs_addr_rdy)
      else fail_run("configuration channel not ready between transfers");
    @(posedge clk);
    #2;
    size_val = 1'b0;
    freq_val = 1'b0;
    cs_addr_val = 1'b0;
    cur_n = size;
    cur_f = fexp;
    cur_cs = sel;
  endtask

  // request, optionally with a full config write on the same edge
  task automatic send_word(input logic [nbits-1:0] word, input logic with_cfg, input int size,
                           input int fexp, input int sel);
    @(posedge clk);
    #2;
    recv_val = 1'b1;
    recv_msg = word;
    if (with_cfg) begin
      size_val = 1'b1;
      size_msg = size_bits'(size);
      freq_val = 1'b1;
      freq_msg = spi_pkg::freq_bits'(fexp);
      cs_addr_val = 1'b1;
      cs_addr_msg = 2'(sel);
    end
    do @(negedge clk); while (!recv_rdy);
    if (with_cfg)
      assert (size_rdy && freq_rdy && cs_addr_rdy)
        else fail_run("configuration channel not ready together with the request");
    @(posedge clk);  // accept edge
    #2;
    recv_val = 1'b0;
    size_val = 1'b0;
    freq_val = 1'b0;
    cs_addr_val = 1'b0;
    slave_reference(ref_reg, word, cur_n, exp_rx, exp_reg);
    ref_reg = exp_reg;
    frame_start = cycle;
    frame_len = 3 + cur_n * (2 << cur_f);
    frame_f = cur_f;
    frame_cs = cur_cs;
    frame_mask = {nbits{1'b1}} >> (nbits - cur_n);
    frame_valid = 1'b1;
    if (with_cfg) begin
      cur_n = size;  // for the next transfer only
      cur_f = fexp;
      cur_cs = sel;
    end
  endtask

  task automatic release_response();
    @(posedge clk);
    #2;
    send_rdy = 1'b1;
    @(posedge clk);
    #2;
    send_rdy = 1'b0;
  endtask

  // compare between edges, outputs settled
  always @(negedge clk) begin
    if (!reset) begin
      assert (uut.master.asrt.fail_count == 0)
        else fail_run("protocol assertion failed in spi_master");
      in_frame = frame_valid && (cycle >= frame_start) && (cycle < frame_start + frame_len);
      for (int i = 0; i < ncs; i++)
        assert (cs[i] === !(in_frame && (i == frame_cs)))
          else value_error($sformatf("cs[%0d]", i), cs[i], !(in_frame && (i == frame_cs)));
      if (sclk) begin
        high_run++;
      end else begin
        if (high_run != 0) begin
          assert (high_run == (1 << frame_f))
            else value_error("sclk high cycles", nbits'(high_run), nbits'(1 << frame_f));
        end
        high_run = 0;
      end
      if (send_val && !send_val_q) begin
        assert (cycle - frame_start == frame_len)
          else value_error("send_val delay", nbits'(cycle - frame_start), nbits'(frame_len));
        assert ((send_msg & frame_mask) == exp_rx)
          else value_error("send_msg", send_msg & frame_mask, exp_rx);
        assert (slave.shreg == exp_reg)
          else value_error("slave register", slave.shreg, exp_reg);
        held_msg = send_msg;
        checked++;
      end else if (send_val) begin
        assert (send_msg == held_msg)
          else value_error("send_msg while held", send_msg, held_msg);
      end
      if (send_val_q && !send_val)
        assert (release_q)
          else fail_run("send_val dropped without send_rdy or a new request");
      send_val_q = send_val;
      release_q = send_rdy || recv_val;
    end
  end

  initial begin
    reset = 1'b1;
    recv_val = 1'b0;
    recv_msg = '0;
    send_rdy = 1'b0;
    size_val = 1'b0;
    size_msg = '0;
    cs_addr_val = 1'b0;
    cs_addr_msg = '0;
    freq_val = 1'b0;
    freq_msg = '0;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    for (t = 0; t < num_transfers; t++) begin
      msg = random_bits(nbits);
      n = int'(random_bits(6) % nbits) + 1;
      f = int'(random_bits(2) % 3);
      c = int'(random_bits(2));
      hold = int'(random_bits(3));
      case (t % 4)
        2: send_word(msg, 1'b1, n, f, c);   // new config rides on the accept edge
        3: send_word(msg, 1'b0, 0, 0, 0);   // first transfer with that config
        default: begin
          write_config(n, f, c);      // may land while the last response waits
          send_word(msg, 1'b0, 0, 0, 0);
        end
      endcase
      do @(negedge clk); while (!send_val);
      repeat (hold) @(posedge clk);   // back-pressure
      if (random_bits(1) == 1 || t == num_transfers - 1)
        release_response();           // else the next request leaves done
    end
    repeat (4) @(posedge clk);
    if (checked == num_transfers) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      fail_run($sformatf("%0d of %0d responses checked", checked, num_transfers));
    end
  end

  // watchdog
  initial begin
    #(limit_ns);
    fail_run("run timed out before all transfers completed");
  end

endmodule

// File: verilog.f
hdl/spi_pkg.sv
hdl/spi_config_regs.sv
hdl/spi_shift_reg.sv
hdl/spi_master.sv
hdl/spi_top.sv
test/spi_slave_model.sv
test/spi_assertions.sv
test/tb_spi_top.sv

// File: Bender.yml
package:
  name: spi_master_subsystem

sources:
  - files:
      - hdl/spi_pkg.sv
      - hdl/spi_config_regs.sv
      - hdl/spi_shift_reg.sv
      - hdl/spi_master.sv
      - hdl/spi_top.sv
  - target: test
    files:
      - test/spi_slave_model.sv
      - test/spi_assertions.sv
      - test/tb_spi_top.sv
